// File: hdl/ppu_reg_pkg.sv
// PPU CPU register map
// Register selects and bit positions of PPUCTRL, PPUMASK and PPUSTATUS
`default_nettype none

package ppu_reg_pkg;

    // Register select on i_rs
    typedef enum logic [2:0] {
        RS_PPUCTRL   = 3'd0,    // Control
        RS_PPUMASK   = 3'd1,    // Rendering mask
        RS_PPUSTATUS = 3'd2,    // Status, read only
        RS_PPUADDR   = 3'd6,    // VRAM address, two writes
        RS_PPUDATA   = 3'd7     // VRAM data port
    } reg_sel_e;

    // Levels of i_rw
    localparam logic RW_READ  = 1'b1;
    localparam logic RW_WRITE = 1'b0;

    // PPUCTRL bits
    localparam int CTRL_INC32  = 2;    // Address step 32 instead of 1
    localparam int CTRL_NMI_EN = 7;    // NMI at start of vblank

    // PPUMASK bits
    localparam int MASK_GREY = 0;      // Greyscale output

    // PPUSTATUS bits
    localparam int STATUS_VBLANK = 7;  // Vblank flag

endpackage

`default_nettype wire

// File: hdl/ppu_video_pkg.sv
// PPU video definitions
// Raster timing, video address and colour types
`default_nettype none

package ppu_video_pkg;

    // Raster size in dots and lines
    localparam int SCREEN_WIDTH          = 341;
    localparam int SCREEN_HEIGHT         = 262;
    localparam int SCREEN_VISIBLE_WIDTH  = 256;
    localparam int SCREEN_VISIBLE_HEIGHT = 240;

    localparam int VBLANK_LINE = 241;  // First line of vblank

    // Dot or line number
    typedef logic [8:0] coord_t;

    // 14-bit video bus address
    typedef logic [13:0] vram_addr_t;

    // Palette window at the top of video space
    localparam vram_addr_t PALETTE_BASE    = 14'h3F00;
    localparam int         PALETTE_ENTRIES = 32;

    // Output pixel
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // Line classes of one frame
    typedef enum logic [1:0] {
        VISIBLE,    // Lines 0 to 239
        POST,       // Line 240, idle
        VBLANK,     // Lines 241 to 260
        PRE         // Line 261, pre-render
    } raster_e;

endpackage

`default_nettype wire

// File: hdl/ppu_ifs.sv
// PPU internal interfaces
// VRAM access requests from the register file, palette RAM access
`timescale 1ns/1ps
`default_nettype none

interface ppu_vram_if;
    logic       addr_hi_we;  // PPUADDR first write
    logic       addr_lo_we;  // PPUADDR second write
    logic       data_we;     // PPUDATA write
    logic       data_re;     // PPUDATA read
    logic [7:0] wdata;       // CPU write data
    logic       inc32;       // Address step select
    logic [7:0] rdata;       // Buffer or palette data back to CPU

    modport ctrl (output addr_hi_we, addr_lo_we, data_we, data_re, wdata, inc32,
                  input  rdata);
    modport port (input  addr_hi_we, addr_lo_we, data_we, data_re, wdata, inc32,
                  output rdata);
endinterface

interface ppu_pal_if;
    logic       we;
    logic [4:0] index;  // Palette entry, before mirroring
    logic [5:0] wdata;
    logic [5:0] rdata;

    modport port (output we, index, wdata, input rdata);
    modport pal  (input  we, index, wdata, output rdata);
endinterface

`default_nettype wire

// File: hdl/ppu_regs.sv
// PPU CPU register file
// Decodes CPU accesses, holds control, mask, vblank flag and address toggle
`timescale 1ns/1ps
`default_nettype none

module ppu_regs
    import ppu_reg_pkg::*;
(
    input  wire logic       i_clk,
    input  wire logic       i_reset_n,
    input  wire logic       i_cs_n,          // Chip select, active low
    input  wire logic       i_rw,            // High read, low write
    input  var  reg_sel_e   i_rs,
    input  wire logic [7:0] i_data,          // From CPU
    output logic [7:0]      o_data,          // To CPU
    input  wire logic       i_vblank_start,
    input  wire logic       i_vblank_end,
    output logic            o_int_n,         // To CPU NMI
    output logic [7:0]      o_ppuctrl,
    output logic [7:0]      o_ppumask,
    ppu_vram_if.ctrl        vram
);

    logic       cpu_rd;
    logic       cpu_wr;
    logic       status_rd;
    logic       addr_wr;
    logic [7:0] ppuctrl;
    logic [7:0] ppumask;
    logic       vblank_flag;   // Set at vblank start, cleared at end or by read
    logic       addr_toggle;   // Low selects the high address byte
    logic [7:0] status;

    assign cpu_rd    = !i_cs_n && (i_rw == RW_READ);
    assign cpu_wr    = !i_cs_n && (i_rw == RW_WRITE);
    assign status_rd = cpu_rd && (i_rs == RS_PPUSTATUS);
    assign addr_wr   = cpu_wr && (i_rs == RS_PPUADDR);

    // Control and mask registers
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            ppuctrl <= '0;
            ppumask <= '0;
        end
        else if (cpu_wr)
        begin
            case (i_rs)
                RS_PPUCTRL: ppuctrl <= i_data;
                RS_PPUMASK: ppumask <= i_data;
                default:
                begin
                end
            endcase
        end
    end

    // Vblank flag and address latch toggle
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            vblank_flag <= 1'b0;
            addr_toggle <= 1'b0;
        end
        else
        begin
            if (i_vblank_start)
                vblank_flag <= 1'b1;
            else if (i_vblank_end || status_rd)
                vblank_flag <= 1'b0;       // Read clears the flag

            if (status_rd)
                addr_toggle <= 1'b0;       // Next PPUADDR write is the high byte
            else if (addr_wr)
                addr_toggle <= !addr_toggle;
        end
    end

    // Only the vblank bit is implemented
    always_comb
    begin
        status                = '0;
        status[STATUS_VBLANK] = vblank_flag;
    end

    // CPU read mux
    always_comb
    begin
        o_data = '0;
        if (!i_cs_n)
        begin
            case (i_rs)
                RS_PPUSTATUS: o_data = status;
                RS_PPUDATA:   o_data = vram.rdata;  // Buffer or palette
                default:      o_data = '0;
            endcase
        end
    end

    // Access strobes towards the VRAM port
    assign vram.addr_hi_we = addr_wr && !addr_toggle;
    assign vram.addr_lo_we = addr_wr && addr_toggle;
    assign vram.data_we    = cpu_wr && (i_rs == RS_PPUDATA);
    assign vram.data_re    = cpu_rd && (i_rs == RS_PPUDATA);
    assign vram.wdata      = i_data;
    assign vram.inc32      = ppuctrl[CTRL_INC32];

    assign o_int_n   = !(vblank_flag && ppuctrl[CTRL_NMI_EN]);  // Low while both set
    assign o_ppuctrl = ppuctrl;
    assign o_ppumask = ppumask;

endmodule

`default_nettype wire

// File: hdl/ppu_raster_timing.sv
// PPU raster timing
// Dot and line counters, visible window and vblank events
`timescale 1ns/1ps
`default_nettype none

module ppu_raster_timing
    import ppu_video_pkg::*;
(
    input  wire logic i_clk,
    input  wire logic i_reset_n,
    output coord_t    o_x,
    output coord_t    o_y,
    output logic      o_visible,
    output logic      o_vblank_start,  // Single cycle at dot 0 of line 241
    output logic      o_vblank_end     // Single cycle at last dot of line 261
);

    coord_t  x;
    coord_t  y;
    raster_e line_class;

    // Dot counter wraps into the line counter
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            x <= '0;
            y <= '0;
        end
        else if (x == coord_t'(SCREEN_WIDTH - 1))
        begin
            x <= '0;
            if (y == coord_t'(SCREEN_HEIGHT - 1))
                y <= '0;                   // New frame
            else
                y <= y + 1'b1;
        end
        else
            x <= x + 1'b1;
    end

    always_comb
    begin
        if (y < SCREEN_VISIBLE_HEIGHT)
            line_class = VISIBLE;
        else if (y < VBLANK_LINE)
            line_class = POST;
        else if (y < SCREEN_HEIGHT - 1)
            line_class = VBLANK;
        else
            line_class = PRE;
    end

    assign o_visible      = (line_class == VISIBLE) && (x < SCREEN_VISIBLE_WIDTH);
    assign o_vblank_start = (y == VBLANK_LINE) && (x == '0);
    assign o_vblank_end   = (line_class == PRE) && (x == coord_t'(SCREEN_WIDTH - 1));
    assign o_x            = x;
    assign o_y            = y;

endmodule

`default_nettype wire

// File: hdl/ppu_vram_port.sv
// PPU VRAM port
// Address register, read buffer and video bus strobes, palette routing
`timescale 1ns/1ps
`default_nettype none

module ppu_vram_port
    import ppu_video_pkg::*;
(
    input  wire logic       i_clk,
    input  wire logic       i_reset_n,
    ppu_vram_if.port        vram,
    ppu_pal_if.port         pal,
    output logic            o_video_rd_n,
    output logic            o_video_we_n,
    output vram_addr_t      o_video_address,
    output logic [7:0]      o_video_data,
    input  wire logic [7:0] i_video_data
);

    vram_addr_t addr;
    vram_addr_t addr_step;
    logic [7:0] rd_buf;      // PPUDATA read buffer
    logic [7:0] wr_data;     // Held for the bus write cycle
    logic       pend_wr;     // Bus write in progress
    logic       pend_rd;     // Bus read in progress
    logic       in_pal;

    assign in_pal    = (addr >= PALETTE_BASE);
    assign addr_step = vram.inc32 ? vram_addr_t'(32) : vram_addr_t'(1);

    // Pending access, one bus cycle after the CPU access
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            pend_wr <= 1'b0;
            pend_rd <= 1'b0;
        end
        else
        begin
            pend_wr <= vram.data_we && !in_pal;
            pend_rd <= vram.data_re && !in_pal;
        end
    end

    // Address load, high byte first, then step after each data access
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            addr <= '0;
        else if (vram.addr_hi_we)
            addr[13:8] <= vram.wdata[5:0];
        else if (vram.addr_lo_we)
            addr[7:0] <= vram.wdata;
        else if (pend_wr || pend_rd || ((vram.data_we || vram.data_re) && in_pal))
            addr <= addr + addr_step;      // Palette accesses step at once
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            rd_buf <= '0;
        else if (pend_rd)
            rd_buf <= i_video_data;        // Captured at the end of the read cycle
    end

    always_ff @(posedge i_clk)
    begin
        if (vram.data_we)
            wr_data <= vram.wdata;
    end

    // Palette window bypasses the video bus
    assign pal.we     = vram.data_we && in_pal;
    assign pal.index  = addr[4:0];
    assign pal.wdata  = vram.wdata[5:0];
    assign vram.rdata = in_pal ? {2'b00, pal.rdata} : rd_buf;

    assign o_video_rd_n    = !pend_rd;
    assign o_video_we_n    = !pend_wr;
    assign o_video_address = addr;     // Old address during the bus cycle
    assign o_video_data    = wr_data;

endmodule

`default_nettype wire

// File: hdl/ppu_palette.sv
// PPU palette
// 32-entry palette RAM and backdrop colour to RGB expansion
`timescale 1ns/1ps
`default_nettype none

module ppu_palette
    import ppu_video_pkg::*;
(
    input  wire logic i_clk,
    input  wire logic i_reset_n,
    ppu_pal_if.pal    pal,
    input  wire logic i_visible,
    input  wire logic i_grey,     // PPUMASK greyscale
    output logic [7:0] o_red,
    output logic [7:0] o_green,
    output logic [7:0] o_blue
);

    logic [5:0] pal_ram [PALETTE_ENTRIES];
    logic [4:0] eff_index;
    logic [5:0] colour;
    rgb_t       rgb_q;

    // Entries 0x10, 0x14, 0x18 and 0x1C mirror the backdrop slots
    assign eff_index = (pal.index[1:0] == 2'b00) ? {1'b0, pal.index[3:0]} : pal.index;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            for (int i = 0; i < PALETTE_ENTRIES; i++)
                pal_ram[i] <= '0;
        end
        else if (pal.we)
            pal_ram[eff_index] <= pal.wdata;
    end

    assign pal.rdata = pal_ram[eff_index];

    // Backdrop entry, top two bits only in greyscale
    assign colour = i_grey ? (pal_ram[0] & 6'h30) : pal_ram[0];

    // Registered pixel, black outside the visible window
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            rgb_q <= '0;
        else if (i_visible)
        begin
            rgb_q.red   <= {4{colour[5:4]}};
            rgb_q.green <= {4{colour[3:2]}};
            rgb_q.blue  <= {4{colour[1:0]}};
        end
        else
            rgb_q <= '0;
    end

    assign o_red   = rgb_q.red;
    assign o_green = rgb_q.green;
    assign o_blue  = rgb_q.blue;

endmodule

`default_nettype wire

// File: hdl/ppu_top.sv
// PPU top level
// Register file, raster timing, VRAM port and palette on plain ports
`timescale 1ns/1ps
`default_nettype none

module ppu_top
    import ppu_reg_pkg::*, ppu_video_pkg::*;
(
    input  wire logic       i_clk,
    input  wire logic       i_reset_n,
    input  wire logic       i_cs_n,
    input  wire logic       i_rw,
    input  wire logic [2:0] i_rs,
    input  wire logic [7:0] i_data,
    output logic [7:0]      o_data,
    output logic            o_int_n,
    output logic            o_video_rd_n,
    output logic            o_video_we_n,
    output vram_addr_t      o_video_address,
    output logic [7:0]      o_video_data,
    input  wire logic [7:0] i_video_data,
    output logic [7:0]      o_video_red,
    output logic [7:0]      o_video_green,
    output logic [7:0]      o_video_blue,
    output coord_t          o_video_x,
    output coord_t          o_video_y,
    output logic            o_video_visible,
    output logic [7:0]      o_debug_ppuctrl,
    output logic [7:0]      o_debug_ppumask
);

    logic vblank_start;
    logic vblank_end;

    ppu_vram_if u_vram_if ();
    ppu_pal_if  u_pal_if ();

    ppu_regs u_regs (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_cs_n         (i_cs_n),
        .i_rw           (i_rw),
        .i_rs           (reg_sel_e'(i_rs)),
        .i_data         (i_data),
        .o_data         (o_data),
        .i_vblank_start (vblank_start),
        .i_vblank_end   (vblank_end),
        .o_int_n        (o_int_n),
        .o_ppuctrl      (o_debug_ppuctrl),
        .o_ppumask      (o_debug_ppumask),
        .vram           (u_vram_if.ctrl)
    );

    ppu_raster_timing u_raster (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .o_x            (o_video_x),
        .o_y            (o_video_y),
        .o_visible      (o_video_visible),
        .o_vblank_start (vblank_start),
        .o_vblank_end   (vblank_end)
    );

    ppu_vram_port u_vram_port (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .vram            (u_vram_if.port),
        .pal             (u_pal_if.port),
        .o_video_rd_n    (o_video_rd_n),
        .o_video_we_n    (o_video_we_n),
        .o_video_address (o_video_address),
        .o_video_data    (o_video_data),
        .i_video_data    (i_video_data)
    );

    ppu_palette u_palette (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .pal       (u_pal_if.pal),
        .i_visible (o_video_visible),
        .i_grey    (o_debug_ppumask[MASK_GREY]),
        .o_red     (o_video_red),
        .o_green   (o_video_green),
        .o_blue    (o_video_blue)
    );

endmodule

`default_nettype wire

// File: tb/ppu_properties.sv
// PPU bus properties
// Video strobe shape, PPUDATA access spacing and NMI output rule
`timescale 1ns/1ps
`default_nettype none

module ppu_properties
    import ppu_reg_pkg::*, ppu_video_pkg::*;
(
    input wire logic       i_clk,
    input wire logic       i_reset_n,
    input wire logic       i_cs_n,
    input wire logic [2:0] i_rs,
    input wire coord_t     i_x,             // Raster dot
    input wire coord_t     i_y,             // Raster line
    input wire logic [7:0] i_ppuctrl,
    input wire logic       i_int_n,
    input wire logic       i_video_rd_n,
    input wire logic       i_video_we_n
);

    logic        data_access;
    raster_e     line_class;
    int unsigned fail_count = 0;   // Failed assertions so far

    assign data_access = !i_cs_n && (i_rs == RS_PPUDATA);

    // Line class from the line number alone
    always_comb
    begin
        if (i_y == coord_t'(SCREEN_HEIGHT - 1))
            line_class = PRE;
        else if (i_y >= coord_t'(VBLANK_LINE))
            line_class = VBLANK;
        else if (i_y >= coord_t'(SCREEN_VISIBLE_HEIGHT))
            line_class = POST;
        else
            line_class = VISIBLE;
    end

    // Both strobes idle once reset has been seen
    strobes_idle_after_reset: assert property (@(posedge i_clk)
        !i_reset_n |=> (i_video_rd_n && i_video_we_n))
        else
        begin
            fail_count++;
            $error("Video strobes active after reset");
        end

    strobes_exclusive: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !(!i_video_rd_n && !i_video_we_n))
        else
        begin
            fail_count++;
            $error("Video read and write strobes low together");
        end

    // Single-cycle strobes
    rd_strobe_one_cycle: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        $fell(i_video_rd_n) |=> i_video_rd_n)
        else
        begin
            fail_count++;
            $error("Video read strobe longer than one cycle");
        end

    we_strobe_one_cycle: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        $fell(i_video_we_n) |=> i_video_we_n)
        else
        begin
            fail_count++;
            $error("Video write strobe longer than one cycle");
        end

    // Two idle cycles after each PPUDATA access
    data_access_spacing: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        data_access |=> !data_access ##1 !data_access)
        else
        begin
            fail_count++;
            $error("PPUDATA accesses closer than two idle cycles");
        end

    // NMI needs the enable bit and a vblank or pre-render line
    int_n_in_vblank: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !i_int_n |-> i_ppuctrl[CTRL_NMI_EN] && (line_class == VBLANK || line_class == PRE))
        else
        begin
            fail_count++;
            $error("NMI output low outside vblank or without enable");
        end

    // Flag is set from the second dot of the first vblank line
    int_n_at_vblank_start: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (i_y == coord_t'(VBLANK_LINE)) && (i_x == coord_t'(1))
            |-> (i_int_n == !i_ppuctrl[CTRL_NMI_EN]))
        else
        begin
            fail_count++;
            $error("NMI output does not follow enable at vblank start");
        end

endmodule

bind ppu_top ppu_properties u_properties (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_cs_n       (i_cs_n),
    .i_rs         (i_rs),
    .i_x          (o_video_x),
    .i_y          (o_video_y),
    .i_ppuctrl    (o_debug_ppuctrl),
    .i_int_n      (o_int_n),
    .i_video_rd_n (o_video_rd_n),
    .i_video_we_n (o_video_we_n)
);

`default_nettype wire

// File: tb/tb_ppu.sv
// PPU testbench
// Directed tests of registers, VRAM port, palette, RGB output and vblank
`timescale 1ns/1ps
`default_nettype none

module tb_ppu
    import ppu_reg_pkg::*, ppu_video_pkg::*;
;

    localparam int BUS_TIMEOUT   = 8;          // Cycles
    localparam int FRAME_TIMEOUT = 100000;     // More than one frame

    logic       i_clk;
    logic       i_reset_n;
    logic       i_cs_n;
    logic       i_rw;
    logic [2:0] i_rs;
    logic [7:0] i_data;
    logic [7:0] o_data;
    logic       o_int_n;
    logic       o_video_rd_n;
    logic       o_video_we_n;
    vram_addr_t o_video_address;
    logic [7:0] o_video_data;
    logic [7:0] i_video_data;
    logic [7:0] o_video_red;
    logic [7:0] o_video_green;
    logic [7:0] o_video_blue;
    coord_t     o_video_x;
    coord_t     o_video_y;
    logic       o_video_visible;
    logic [7:0] o_debug_ppuctrl;
    logic [7:0] o_debug_ppumask;

    logic [7:0] vram_mem [16384];   // Video memory model
    vram_addr_t last_wr_addr;
    logic [7:0] last_wr_data;
    vram_addr_t last_rd_addr;
    int         wr_count = 0;
    int         rd_count = 0;
    logic [7:0] exp_buf = 8'h00;    // Read buffer is cleared by reset
    logic [5:0] exp_pal [32];

    ppu_top i_dut (
        .i_clk (i_clk), .i_reset_n (i_reset_n), .i_cs_n (i_cs_n), .i_rw (i_rw),
        .i_rs (i_rs), .i_data (i_data), .o_data (o_data), .o_int_n (o_int_n),
        .o_video_rd_n (o_video_rd_n), .o_video_we_n (o_video_we_n),
        .o_video_address (o_video_address), .o_video_data (o_video_data),
        .i_video_data (i_video_data), .o_video_red (o_video_red),
        .o_video_green (o_video_green), .o_video_blue (o_video_blue),
        .o_video_x (o_video_x), .o_video_y (o_video_y),
        .o_video_visible (o_video_visible), .o_debug_ppuctrl (o_debug_ppuctrl),
        .o_debug_ppumask (o_debug_ppumask)
    );

    always #10 i_clk = !i_clk;

    assign i_video_data = vram_mem[o_video_address];   // Combinational read

    // Bus cycles seen by the memory model
    always @(posedge i_clk)
    begin
        if (i_reset_n && !o_video_we_n)
        begin
            vram_mem[o_video_address] <= o_video_data;
            last_wr_addr <= o_video_address;
            last_wr_data <= o_video_data;
            wr_count     <= wr_count + 1;
        end
        if (i_reset_n && !o_video_rd_n)
        begin
            last_rd_addr <= o_video_address;
            rd_count     <= rd_count + 1;
        end
    end

    function automatic logic [7:0] fill_byte(input vram_addr_t a);
        return a[7:0] ^ {a[13:8], 2'b10};
    endfunction

    // Backdrop slots of the sprite half map to the background half
    function automatic logic [4:0] pal_slot(input logic [4:0] idx);
        case (idx)
            5'h10, 5'h14, 5'h18, 5'h1C: return idx - 5'h10;
            default:                    return idx;
        endcase
    endfunction

    task automatic fail_test(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // Bound checker assertion count
    always @(i_dut.u_properties.fail_count)
    begin
        if (i_dut.u_properties.fail_count != 0)
            fail_test("An assertion of the bus properties failed");
    end

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
            fail_test($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_test($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic check_addr(input string name, input vram_addr_t exp, input vram_addr_t act);
        if (act !== exp)
            fail_test($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (act !== exp)
            fail_test($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_coord(input string name, input coord_t exp, input coord_t act);
        if (act !== exp)
            fail_test($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
    endtask

    // One CPU access, then two idle cycles; entered and left 1 ns after a rising edge
    task automatic cpu_access(input logic rw, input reg_sel_e rs, input logic [7:0] wdata,
                              output logic [7:0] rdata);
        i_cs_n = 1'b0;
        i_rw   = rw;
        i_rs   = rs;
        i_data = wdata;
        @(negedge i_clk);
        rdata = o_data;             // Stable mid-cycle
        @(posedge i_clk);
        #1;
        i_cs_n = 1'b1;
        i_rw   = RW_READ;
        i_data = '0;
        repeat (2) @(posedge i_clk);
        #1;
    endtask

    task automatic cpu_write(input reg_sel_e rs, input logic [7:0] wdata);
        logic [7:0] unused;
        cpu_access(RW_WRITE, rs, wdata, unused);
    endtask

    task automatic cpu_read(input reg_sel_e rs, output logic [7:0] rdata);
        cpu_access(RW_READ, rs, 8'h00, rdata);
    endtask

    task automatic set_vram_addr(input vram_addr_t a);
        logic [7:0] d;
        cpu_read(RS_PPUSTATUS, d);  // Resets the address toggle
        cpu_write(RS_PPUADDR, {2'b00, a[13:8]});
        cpu_write(RS_PPUADDR, a[7:0]);
    endtask

    task automatic wait_bus_count(input int start, input logic is_write);
        int cycles;
        cycles = 0;
        while ((is_write ? wr_count : rd_count) == start)
        begin
            if (cycles == BUS_TIMEOUT)
                fail_test("Timeout waiting for a video bus cycle after a PPUDATA access");
            @(posedge i_clk);
            #1;
            cycles++;
        end
    endtask

    // Samples at falling edges until the line number matches
    task automatic wait_line(input coord_t line);
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge i_clk);
            cycles++;
            if (cycles > FRAME_TIMEOUT)
                fail_test($sformatf("Timeout waiting for line %0d", line));
        end
        while (o_video_y != line);
    endtask

    task automatic wait_visible(input logic level);
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge i_clk);
            cycles++;
            if (cycles > FRAME_TIMEOUT)
                fail_test("Timeout waiting for a change of the visible window");
        end
        while (o_video_visible != level);
    endtask

    task automatic test_registers();
        logic [7:0] ctrl_val;
        logic [7:0] mask_val;
        logic [7:0] d;
        ctrl_val = 8'($urandom);
        mask_val = 8'($urandom);
        cpu_write(RS_PPUCTRL, ctrl_val);
        cpu_write(RS_PPUMASK, mask_val);
        check_byte("debug_ppuctrl", ctrl_val, o_debug_ppuctrl);
        check_byte("debug_ppumask", mask_val, o_debug_ppumask);
        cpu_read(RS_PPUCTRL, d);
        check_byte("read_ppuctrl", 8'h00, d);   // Write-only registers read as 0
        cpu_read(RS_PPUMASK, d);
        check_byte("read_ppumask", 8'h00, d);
        cpu_read(RS_PPUADDR, d);
        check_byte("read_ppuaddr", 8'h00, d);
        cpu_write(RS_PPUCTRL, 8'h00);
        cpu_write(RS_PPUMASK, 8'h00);
    endtask

    task automatic test_vram_write();
        vram_addr_t exp_addr;
        logic [7:0] d;
        int         start;
        set_vram_addr(14'h0123);
        exp_addr = 14'h0123;
        for (int i = 0; i < 7; i++)
        begin
            if (i == 4)
                cpu_write(RS_PPUCTRL, 8'(1 << CTRL_INC32));   // Step 32 from here
            d     = 8'($urandom);
            start = wr_count;
            cpu_write(RS_PPUDATA, d);
            wait_bus_count(start, 1'b1);
            check_addr("vram_write", exp_addr, last_wr_addr);
            check_byte("vram_write", d, last_wr_data);
            check_byte("vram_write_model", d, vram_mem[exp_addr]);
            exp_addr = exp_addr + ((i >= 4) ? 14'd32 : 14'd1);
        end
        cpu_write(RS_PPUCTRL, 8'h00);
    endtask

    task automatic test_vram_read();
        vram_addr_t exp_addr;
        logic [7:0] d;
        int         start;
        set_vram_addr(14'h0200);
        exp_addr = 14'h0200;
        for (int i = 0; i < 4; i++)
        begin
            start = rd_count;
            cpu_read(RS_PPUDATA, d);
            check_byte("vram_read", exp_buf, d);        // Previous buffer content
            wait_bus_count(start, 1'b0);
            check_addr("vram_read_addr", exp_addr, last_rd_addr);
            exp_buf  = vram_mem[exp_addr];
            exp_addr = exp_addr + 14'd1;
        end
    endtask

    task automatic check_pixel(input logic grey);
        logic [5:0] c;
        rgb_t       exp;
        cpu_write(RS_PPUMASK, grey ? 8'(1 << MASK_GREY) : 8'h00);
        c         = grey ? {exp_pal[0][5:4], 4'h0} : exp_pal[0];
        exp.red   = 8'h55 * c[5:4];              // Field repeated four times
        exp.green = 8'h55 * c[3:2];
        exp.blue  = 8'h55 * c[1:0];
        wait_visible(1'b1);
        @(negedge i_clk);                       // Output is one cycle late
        check_rgb("rgb_visible", exp, {o_video_red, o_video_green, o_video_blue});
        wait_visible(1'b0);
        check_coord("visible_end_x", coord_t'(SCREEN_VISIBLE_WIDTH), o_video_x);
        @(negedge i_clk);
        check_rgb("rgb_blank", '0, {o_video_red, o_video_green, o_video_blue});
        @(posedge i_clk);
        #1;
    endtask

    task automatic test_palette();
        logic [7:0] d;
        logic [4:0] idx;
        int         start;
        foreach (exp_pal[i])
            exp_pal[i] = '0;
        start = wr_count;
        set_vram_addr(PALETTE_BASE);
        for (int i = 0; i < 8; i++)
        begin
            d = 8'($urandom);
            if (i == 0)
                d = d | 8'h21;                  // Backdrop visible in greyscale too
            cpu_write(RS_PPUDATA, d);
            exp_pal[pal_slot(5'(i))] = d[5:0];
        end
        set_vram_addr(PALETTE_BASE + 14'h14);   // Mirror of entry 4
        d = 8'($urandom);
        cpu_write(RS_PPUDATA, d);
        exp_pal[pal_slot(5'h14)] = d[5:0];
        if (wr_count != start)
            fail_test("A palette write made a video bus write");
        set_vram_addr(PALETTE_BASE);
        start = rd_count;
        for (int i = 0; i < 24; i++)
        begin
            idx = 5'(i);
            cpu_read(RS_PPUDATA, d);
            check_byte("palette_read", {2'b00, exp_pal[pal_slot(idx)]}, d);
        end
        if (rd_count != start)
            fail_test("A palette read made a video bus read");
        check_pixel(1'b0);
        check_pixel(1'b1);
        cpu_write(RS_PPUMASK, 8'h00);
    endtask

    task automatic test_vblank();
        logic [7:0] d;
        cpu_write(RS_PPUCTRL, 8'h00);
        wait_line(coord_t'(VBLANK_LINE - 1));   // Start from a fresh frame
        wait_line(coord_t'(VBLANK_LINE));
        @(posedge i_clk);
        #1;
        check_bit("nmi_disabled", 1'b1, o_int_n);
        check_bit("visible_vblank", 1'b0, o_video_visible);
        cpu_write(RS_PPUCTRL, 8'(1 << CTRL_NMI_EN));
        check_bit("nmi_enabled", 1'b0, o_int_n);
        cpu_read(RS_PPUSTATUS, d);
        check_byte("status_vblank", 8'(1 << STATUS_VBLANK), d);
        cpu_read(RS_PPUSTATUS, d);
        check_byte("status_cleared", 8'h00, d);  // Read cleared the flag
        check_bit("nmi_after_read", 1'b1, o_int_n);
        cpu_write(RS_PPUCTRL, 8'h00);
        wait_line(coord_t'(SCREEN_HEIGHT - 1));
        wait_line(coord_t'(0));
        check_coord("wrap_x", coord_t'(0), o_video_x);
        check_coord("wrap_y", coord_t'(0), o_video_y);
        check_bit("visible_origin", 1'b1, o_video_visible);
        @(posedge i_clk);
        #1;
    endtask

    initial
    begin
        void'($urandom(32'h9a9d_a7a5));
        i_clk     = 1'b0;
        i_reset_n = 1'b0;
        i_cs_n    = 1'b1;
        i_rw      = RW_READ;
        i_rs      = '0;
        i_data    = '0;
        for (int a = 0; a < 16384; a++)
            vram_mem[a] = fill_byte(vram_addr_t'(a));
        repeat (3) @(posedge i_clk);
        #1;
        i_reset_n = 1'b1;
        test_registers();
        test_vram_write();
        test_vram_read();
        test_palette();
        test_vblank();
        if (i_dut.u_properties.fail_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hdl/ppu_reg_pkg.sv
hdl/ppu_video_pkg.sv
hdl/ppu_ifs.sv
hdl/ppu_regs.sv
hdl/ppu_raster_timing.sv
hdl/ppu_vram_port.sv
hdl/ppu_palette.sv
hdl/ppu_top.sv
tb/ppu_properties.sv
tb/tb_ppu.sv
